/* verilog/cpu_ctrl_pkg.sv */
package cpu_ctrl_pkg;

    // ======================================================================
    // Instruction set
    // ======================================================================
    typedef enum logic [7:0] {
        NOP    = 8'h00,
        HLT    = 8'h01,
        LDI_A  = 8'h10,
        ANI    = 8'h11,
        LDA    = 8'h20,
        STA    = 8'h21,
        JMP    = 8'h30,
        JZ     = 8'h31,
        JNZ    = 8'h32,
        JN     = 8'h33,
        ADD_B  = 8'h40,
        SUB_B  = 8'h41,
        ANA_B  = 8'h42,
        CMP_B  = 8'h43,
        MOV_AB = 8'h50,
        MOV_BA = 8'h51,
        PHA    = 8'h60,
        PLA    = 8'h61
    } opcode_t;

    // Sequencer states
    typedef enum logic [2:0] {
        S_RESET          = 3'd0,
        S_INIT           = 3'd1,
        S_LATCH_ADDR     = 3'd2,
        S_READ_BYTE      = 3'd3,
        S_LATCH_BYTE     = 3'd4,
        S_CHK_MORE_BYTES = 3'd5,
        S_EXECUTE        = 3'd6,
        S_HALT           = 3'd7
    } fsm_state_t;

    typedef enum logic [1:0] {
        ALU_NONE = 2'd0,
        ALU_ADD  = 2'd1,
        ALU_SUB  = 2'd2,
        ALU_AND  = 2'd3
    } alu_op_t;

    // ======================================================================
    // Control word to the datapath
    // ======================================================================
    typedef struct packed {
        logic    load_origin;        // PC to reset vector
        logic    load_sp_default;
        logic    load_mar_pc;
        logic    load_mar_sp;
        logic    load_mar_addr_low;
        logic    load_mar_addr_high;
        logic    oe_ram;
        logic    load_ram;
        logic    pc_enable;          // PC increment
        logic    load_ir;
        logic    load_temp_1;
        logic    load_temp_2;
        logic    oe_temp_1;
        logic    oe_temp_2;
        logic    load_pc_low_byte;
        logic    load_pc_high_byte;
        logic    check_zero;
        logic    check_not_zero;
        logic    check_negative;
        logic    halt;
        logic    last_step;
        alu_op_t alu_op;
        logic    alu_src2_temp1;     // Immediate operand instead of B
        logic    oe_alu;
        logic    load_a;
        logic    load_b;
        logic    oe_a;
        logic    oe_b;
        logic    load_status;
        logic    load_sets_zn;       // Z/N from the bus value instead of the ALU
        logic    sp_dec;
        logic    sp_inc;
    } control_word_t;

    // Status flag positions
    localparam int FLAG_WIDTH = 3;
    localparam int FLAG_ZERO  = 0;
    localparam int FLAG_CARRY = 1;
    localparam int FLAG_NEG   = 2;

endpackage

/* verilog/microcode_store.sv */
`timescale 1ns/1ns

module microcode_store #(
    parameter int MICROSTEP_BITS = 3
) (
    input  cpu_ctrl_pkg::opcode_t       opcode,
    input  logic [MICROSTEP_BITS-1:0]   microstep,
    output logic [1:0]                  operand_count,
    output cpu_ctrl_pkg::control_word_t rom_word
);

    import cpu_ctrl_pkg::*;

    // ======================================================================
    // Operand bytes per opcode
    // ======================================================================
    always_comb begin
        case (opcode)
            LDI_A, ANI:                      operand_count = 2'd1;
            LDA, STA, JMP, JZ, JNZ, JN:      operand_count = 2'd2;
            default:                         operand_count = 2'd0; // Unknown ones too
        endcase
    end

    // ======================================================================
    // Microcode table
    // ======================================================================
    always_comb begin
        rom_word = '0;
        case (opcode)
            NOP: begin
                if (microstep == 0) rom_word.last_step = 1'b1;
            end

            HLT: begin
                if (microstep == 0) rom_word.halt = 1'b1;
            end

            // Low byte first and the check decides whether step 1 happens
            JMP, JZ, JNZ, JN: begin
                case (microstep)
                    0: begin
                        rom_word.oe_temp_1        = 1'b1;
                        rom_word.load_pc_low_byte = 1'b1;
                        rom_word.check_zero       = (opcode == JZ);
                        rom_word.check_not_zero   = (opcode == JNZ);
                        rom_word.check_negative   = (opcode == JN);
                    end
                    1: begin
                        rom_word.oe_temp_2         = 1'b1;
                        rom_word.load_pc_high_byte = 1'b1;
                        rom_word.last_step         = 1'b1;
                    end
                    default: ;
                endcase
            end

            ADD_B, SUB_B, ANA_B, CMP_B, ANI: begin
                case (microstep)
                    0: begin
                        case (opcode)
                            ADD_B:          rom_word.alu_op = ALU_ADD;
                            SUB_B, CMP_B:   rom_word.alu_op = ALU_SUB;
                            default:        rom_word.alu_op = ALU_AND;
                        endcase
                        rom_word.oe_temp_1      = (opcode == ANI);
                        rom_word.alu_src2_temp1 = (opcode == ANI);
                    end
                    1: begin
                        // Compare only updates the flags
                        rom_word.oe_alu      = (opcode != CMP_B);
                        rom_word.load_a      = (opcode != CMP_B);
                        rom_word.load_status = 1'b1;
                        rom_word.last_step   = 1'b1;
                    end
                    default: ;
                endcase
            end

            MOV_AB, MOV_BA: begin
                if (microstep == 0) begin
                    rom_word.oe_a      = (opcode == MOV_AB);
                    rom_word.load_b    = (opcode == MOV_AB);
                    rom_word.oe_b      = (opcode == MOV_BA);
                    rom_word.load_a    = (opcode == MOV_BA);
                    rom_word.last_step = 1'b1;
                end
            end

            LDI_A: begin
                if (microstep == 0) begin
                    rom_word.oe_temp_1    = 1'b1;
                    rom_word.load_a       = 1'b1;
                    rom_word.load_status  = 1'b1;
                    rom_word.load_sets_zn = 1'b1;
                    rom_word.last_step    = 1'b1;
                end
            end

            // Address into MAR in two halves, then the data transfer
            LDA, STA: begin
                case (microstep)
                    0: rom_word.oe_temp_1 = 1'b1;
                    1: begin
                        rom_word.oe_temp_1         = 1'b1;
                        rom_word.load_mar_addr_low = 1'b1;
                    end
                    2: rom_word.oe_temp_2 = 1'b1;
                    3: begin
                        rom_word.oe_temp_2          = 1'b1;
                        rom_word.load_mar_addr_high = 1'b1;
                    end
                    4: begin
                        rom_word.oe_ram = (opcode == LDA);
                        rom_word.oe_a   = (opcode == STA);
                    end
                    5: begin
                        rom_word.oe_ram       = (opcode == LDA);
                        rom_word.load_a       = (opcode == LDA);
                        rom_word.load_status  = (opcode == LDA);
                        rom_word.load_sets_zn = (opcode == LDA);
                        rom_word.oe_a         = (opcode == STA);
                        rom_word.load_ram     = (opcode == STA);
                        rom_word.last_step    = 1'b1;
                    end
                    default: ;
                endcase
            end

            // Empty descending stack
            PHA: begin
                case (microstep)
                    0: rom_word.load_mar_sp = 1'b1;
                    1: rom_word.sp_dec      = 1'b1;
                    2: rom_word.oe_a        = 1'b1;
                    3: begin
                        rom_word.oe_a      = 1'b1;
                        rom_word.load_ram  = 1'b1;
                        rom_word.last_step = 1'b1;
                    end
                    default: ;
                endcase
            end

            PLA: begin
                case (microstep)
                    0: rom_word.sp_inc      = 1'b1;
                    1: rom_word.load_mar_sp = 1'b1;
                    2: rom_word.oe_ram      = 1'b1;
                    3: begin
                        rom_word.oe_ram       = 1'b1;
                        rom_word.load_a       = 1'b1;
                        rom_word.load_status  = 1'b1;
                        rom_word.load_sets_zn = 1'b1;
                        rom_word.last_step    = 1'b1;
                    end
                    default: ;
                endcase
            end

            default: begin
                if (microstep == 0) rom_word.halt = 1'b1; // Unknown opcode stops the CPU
            end
        endcase
    end

endmodule

/* verilog/fetch_sequencer.sv */
`timescale 1ns/1ns

module fetch_sequencer #(
    parameter int MICROSTEP_BITS = 3
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic [1:0]                  operand_count,
    input  logic                        step_end,
    input  logic                        halt_req,
    output cpu_ctrl_pkg::control_word_t fetch_word,
    output logic                        executing,
    output logic [MICROSTEP_BITS-1:0]   microstep
);

    import cpu_ctrl_pkg::*;

    fsm_state_t                state;
    fsm_state_t                state_next;
    logic [1:0]                byte_count;      // Bytes of this instruction latched so far
    logic [1:0]                byte_count_next;
    logic [MICROSTEP_BITS-1:0] microstep_next;

    // ======================================================================
    // State registers
    // ======================================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= S_RESET;
            byte_count <= 2'd0;
            microstep  <= '0;
        end else begin
            state      <= state_next;
            byte_count <= byte_count_next;
            microstep  <= microstep_next;
        end
    end

    // ======================================================================
    // Next state and fetch-phase bits
    // ======================================================================
    always_comb begin
        state_next      = state;
        byte_count_next = byte_count;
        microstep_next  = microstep;
        fetch_word      = '0;

        case (state)
            S_RESET: state_next = S_INIT;

            S_INIT: begin
                fetch_word.load_origin     = 1'b1;
                fetch_word.load_sp_default = 1'b1;
                state_next                 = S_LATCH_ADDR;
            end

            S_LATCH_ADDR: begin
                fetch_word.load_mar_pc = 1'b1;
                state_next             = S_READ_BYTE;
            end

            S_READ_BYTE: begin
                fetch_word.oe_ram = 1'b1;  // Give RAM a cycle to drive the bus
                state_next        = S_LATCH_BYTE;
            end

            S_LATCH_BYTE: begin
                fetch_word.oe_ram    = 1'b1;
                fetch_word.pc_enable = 1'b1;
                // Opcode first, then the operands in order
                case (byte_count)
                    2'd0:    fetch_word.load_ir     = 1'b1;
                    2'd1:    fetch_word.load_temp_1 = 1'b1;
                    2'd2:    fetch_word.load_temp_2 = 1'b1;
                    default: ;
                endcase
                byte_count_next = byte_count + 2'd1;
                state_next      = S_CHK_MORE_BYTES;
            end

            // Opcode is already in the IR here, so operand_count is valid
            S_CHK_MORE_BYTES: begin
                if (byte_count > operand_count) begin
                    byte_count_next = 2'd0;
                    state_next      = S_EXECUTE;
                end else begin
                    state_next = S_LATCH_ADDR;
                end
            end

            S_EXECUTE: begin
                if (halt_req) begin
                    microstep_next = '0;
                    state_next     = S_HALT;
                end else if (step_end) begin
                    microstep_next = '0;
                    state_next     = S_LATCH_ADDR;
                end else begin
                    microstep_next = microstep + 1'b1;
                end
            end

            S_HALT: state_next = S_HALT; // Only reset leaves

            default: state_next = S_HALT;
        endcase
    end

    assign executing = (state == S_EXECUTE);

endmodule

/* verilog/step_resolver.sv */
`timescale 1ns/1ns

module step_resolver (
    input  logic                                  executing,
    input  cpu_ctrl_pkg::control_word_t           rom_word,
    input  logic [cpu_ctrl_pkg::FLAG_WIDTH-1:0]   flags,
    input  cpu_ctrl_pkg::control_word_t           fetch_word,
    output logic                                  step_end,
    output logic                                  halt_req,
    output cpu_ctrl_pkg::control_word_t           control_word
);

    import cpu_ctrl_pkg::*;

    logic check_any;   // Step carries a branch condition
    logic cond_met;
    logic cond_fail;

    // ======================================================================
    // Branch conditions
    // ======================================================================
    assign check_any = rom_word.check_zero | rom_word.check_not_zero |
                       rom_word.check_negative;

    assign cond_met = (rom_word.check_zero     &  flags[FLAG_ZERO]) |
                      (rom_word.check_not_zero & ~flags[FLAG_ZERO]) |
                      (rom_word.check_negative &  flags[FLAG_NEG]);

    assign cond_fail = executing & check_any & ~cond_met;

    // Untaken branch finishes the instruction early
    assign step_end = executing & (cond_fail | rom_word.last_step);
    assign halt_req = executing & rom_word.halt;

    // ======================================================================
    // Output word
    // ======================================================================
    always_comb begin
        if (executing) begin
            control_word = rom_word;
            if (cond_fail) begin
                control_word.load_pc_low_byte  = 1'b0; // Keep the sequential PC
                control_word.load_pc_high_byte = 1'b0;
            end
        end else begin
            control_word = fetch_word;
        end
    end

endmodule

/* verilog/cpu_control.sv */
`timescale 1ns/1ns

module cpu_control #(
    parameter int MICROSTEP_BITS = 3
) (
    input  logic                                clk,
    input  logic                                reset,
    input  cpu_ctrl_pkg::opcode_t               opcode,
    input  logic [cpu_ctrl_pkg::FLAG_WIDTH-1:0] flags,
    output cpu_ctrl_pkg::control_word_t         control_word
);

    import cpu_ctrl_pkg::*;

    logic [1:0]                operand_count;
    logic [MICROSTEP_BITS-1:0] microstep;
    control_word_t             rom_word;
    control_word_t             fetch_word;
    logic                      executing;
    logic                      step_end;
    logic                      halt_req;

    // Opcode and step to microcode word
    microcode_store #(
        .MICROSTEP_BITS (MICROSTEP_BITS)
    ) u_microcode_store (
        .opcode        (opcode),
        .microstep     (microstep),
        .operand_count (operand_count),
        .rom_word      (rom_word)
    );

    fetch_sequencer #(
        .MICROSTEP_BITS (MICROSTEP_BITS)
    ) u_fetch_sequencer (
        .clk           (clk),
        .reset         (reset),
        .operand_count (operand_count),
        .step_end      (step_end),
        .halt_req      (halt_req),
        .fetch_word    (fetch_word),
        .executing     (executing),
        .microstep     (microstep)
    );

    step_resolver u_step_resolver (
        .executing    (executing),
        .rom_word     (rom_word),
        .flags        (flags),
        .fetch_word   (fetch_word),
        .step_end     (step_end),
        .halt_req     (halt_req),
        .control_word (control_word)
    );

endmodule

/* sim/tb_ref_model.svh */
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// Phases of the fixed control schedule
localparam int PH_IDLE  = 0;    // Reset and the cycle after it
localparam int PH_INIT  = 1;
localparam int PH_ADDR  = 2;
localparam int PH_READ  = 3;
localparam int PH_LATCH = 4;
localparam int PH_CHECK = 5;
localparam int PH_EXEC  = 6;
localparam int PH_HALT  = 7;

// ======================================================================
// Instruction properties
// ======================================================================
function automatic int ref_operand_count(logic [7:0] op);
    case (op)
        LDI_A, ANI:                 return 1;
        LDA, STA, JMP, JZ, JNZ, JN: return 2;
        default:                    return 0;
    endcase
endfunction

function automatic logic jump_taken(logic [7:0] op, logic [FLAG_WIDTH-1:0] flg);
    case (op)
        JZ:      return flg[FLAG_ZERO];
        JNZ:     return !flg[FLAG_ZERO];
        JN:      return flg[FLAG_NEG];
        default: return 1'b1;    // JMP always jumps
    endcase
endfunction

// Execute cycles of one instruction or 0 for a halting one
function automatic int ref_exec_steps(logic [7:0] op, logic [FLAG_WIDTH-1:0] flg);
    case (op)
        NOP, LDI_A, MOV_AB, MOV_BA:      return 1;
        ANI, ADD_B, SUB_B, ANA_B, CMP_B: return 2;
        JMP, JZ, JNZ, JN:                return jump_taken(op, flg) ? 2 : 1;
        PHA, PLA:                        return 4;
        LDA, STA:                        return 6;
        default:                         return 0;
    endcase
endfunction

// ======================================================================
// Expected control word
// ======================================================================
function automatic control_word_t ref_word(int phase, int byte_num, logic [7:0] op,
                                           int step, logic [FLAG_WIDTH-1:0] flg);
    control_word_t w;
    w = '0;
    case (phase)
        PH_INIT: begin
            w.load_origin     = 1'b1;
            w.load_sp_default = 1'b1;
        end
        PH_ADDR: w.load_mar_pc = 1'b1;
        PH_READ: w.oe_ram = 1'b1;
        PH_LATCH: begin
            w.oe_ram      = 1'b1;
            w.pc_enable   = 1'b1;
            w.load_ir     = (byte_num == 0);
            w.load_temp_1 = (byte_num == 1);
            w.load_temp_2 = (byte_num == 2);
        end
        PH_EXEC: begin
            case (op)
                NOP: w.last_step = 1'b1;
                MOV_AB, MOV_BA: begin
                    w.oe_a      = (op == MOV_AB);
                    w.load_b    = (op == MOV_AB);
                    w.oe_b      = (op == MOV_BA);
                    w.load_a    = (op == MOV_BA);
                    w.last_step = 1'b1;
                end
                LDI_A: begin
                    w.oe_temp_1    = 1'b1;
                    w.load_a       = 1'b1;
                    w.load_status  = 1'b1;
                    w.load_sets_zn = 1'b1;
                    w.last_step    = 1'b1;
                end
                ANI, ADD_B, SUB_B, ANA_B, CMP_B: begin
                    if (step == 0) begin
                        if (op == ADD_B) begin
                            w.alu_op = ALU_ADD;
                        end else if (op == SUB_B || op == CMP_B) begin
                            w.alu_op = ALU_SUB;
                        end else begin
                            w.alu_op = ALU_AND;
                        end
                        w.oe_temp_1      = (op == ANI);
                        w.alu_src2_temp1 = (op == ANI);
                    end else begin
                        w.oe_alu      = (op != CMP_B);  // Compare keeps A
                        w.load_a      = (op != CMP_B);
                        w.load_status = 1'b1;
                        w.last_step   = 1'b1;
                    end
                end
                JMP, JZ, JNZ, JN: begin
                    if (step == 0) begin
                        w.oe_temp_1        = 1'b1;
                        w.load_pc_low_byte = jump_taken(op, flg);
                        w.check_zero       = (op == JZ);
                        w.check_not_zero   = (op == JNZ);
                        w.check_negative   = (op == JN);
                    end else begin
                        w.oe_temp_2         = 1'b1;
                        w.load_pc_high_byte = 1'b1;
                        w.last_step         = 1'b1;
                    end
                end
                LDA, STA: begin
                    w.oe_temp_1          = (step <= 1);
                    w.load_mar_addr_low  = (step == 1);
                    w.oe_temp_2          = (step == 2 || step == 3);
                    w.load_mar_addr_high = (step == 3);
                    w.oe_ram             = (op == LDA) && (step >= 4);
                    w.oe_a               = (op == STA) && (step >= 4);
                    w.load_a             = (op == LDA) && (step == 5);
                    w.load_status        = (op == LDA) && (step == 5);
                    w.load_sets_zn       = (op == LDA) && (step == 5);
                    w.load_ram           = (op == STA) && (step == 5);
                    w.last_step          = (step == 5);
                end
                PHA: begin
                    w.load_mar_sp = (step == 0);
                    w.sp_dec      = (step == 1);
                    w.oe_a        = (step >= 2);
                    w.load_ram    = (step == 3);
                    w.last_step   = (step == 3);
                end
                PLA: begin
                    w.sp_inc       = (step == 0);
                    w.load_mar_sp  = (step == 1);
                    w.oe_ram       = (step >= 2);
                    w.load_a       = (step == 3);
                    w.load_status  = (step == 3);
                    w.load_sets_zn = (step == 3);
                    w.last_step    = (step == 3);
                end
                default: w.halt = (step == 0);  // HLT and unknown opcodes
            endcase
        end
        default: ;
    endcase
    return w;
endfunction

`endif

/* sim/tb_cpu_control.sv */
`timescale 1ns/1ns

module tb_cpu_control;

    import cpu_ctrl_pkg::*;

    `include "tb_ref_model.svh"

    localparam int MICROSTEP_BITS = 3;
    localparam int N_RANDOM       = 200;
    localparam int N_JUMPS        = 40;
    // Every program ends with a halting opcode
    localparam int N_INSTR        = 2 + 18 + (N_RANDOM + 1) + (N_JUMPS + 1) + 1 + 1;
    localparam int CYCLE_LIMIT    = N_INSTR * 18 + 100;

    logic                  clk;
    logic                  reset;
    opcode_t               opcode;
    logic [FLAG_WIDTH-1:0] flags;
    control_word_t         control_word;

    logic [7:0] prog[$];            // Opcodes still to be fetched
    logic [7:0] plain_ops[13] = '{NOP, LDI_A, ANI, LDA, STA, ADD_B, SUB_B, ANA_B,
                                  CMP_B, MOV_AB, MOV_BA, PHA, PLA};
    logic [7:0] jump_ops[4]   = '{JMP, JZ, JNZ, JN};
    logic       ir_load_seen  = 1'b0;
    logic       armed         = 1'b0;
    int         phase         = PH_IDLE;
    int         byte_num      = 0;
    int         step          = 0;
    int         err_count     = 0;
    int         tests_run     = 0;
    int         tests_failed  = 0;
    int         cycles        = 0;

    cpu_control #(
        .MICROSTEP_BITS (MICROSTEP_BITS)
    ) u_cpu_control (
        .clk          (clk),
        .reset        (reset),
        .opcode       (opcode),
        .flags        (flags),
        .control_word (control_word)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ======================================================================
    // Instruction register and flags of the outside datapath
    // ======================================================================
    always @(posedge clk) ir_load_seen <= control_word.load_ir;

    always @(negedge clk) begin
        if (ir_load_seen && prog.size() > 0) begin
            opcode = opcode_t'(prog.pop_front());
            flags  = FLAG_WIDTH'($urandom);     // New flags for each instruction
        end
    end

    // ======================================================================
    // Compare process following the schedule phase by phase
    // ======================================================================
    always @(posedge clk) begin : compare
        control_word_t exp;
        int            n_steps;
        exp     = ref_word(phase, byte_num, opcode, step, flags);
        n_steps = ref_exec_steps(opcode, flags);
        if (armed) begin
            word_ok: assert (control_word === exp) else begin
                $display("ERR control_word expected %h actual %h", exp, control_word);
                err_count++;
            end
        end
        if (reset) begin
            armed    <= 1'b1;
            phase    <= PH_IDLE;
            byte_num <= 0;
            step     <= 0;
        end else begin
            case (phase)
                PH_IDLE:  phase <= PH_INIT;
                PH_INIT:  phase <= PH_ADDR;
                PH_ADDR:  phase <= PH_READ;
                PH_READ:  phase <= PH_LATCH;
                PH_LATCH: begin
                    phase    <= PH_CHECK;
                    byte_num <= byte_num + 1;
                end
                PH_CHECK: begin
                    if (byte_num > ref_operand_count(opcode)) begin
                        phase    <= PH_EXEC;
                        byte_num <= 0;
                        step     <= 0;
                    end else begin
                        phase <= PH_ADDR;
                    end
                end
                PH_EXEC: begin
                    if (n_steps == 0) begin
                        phase <= PH_HALT;
                    end else if (step == n_steps - 1) begin
                        phase <= PH_ADDR;   // Next fetch starts at once
                        step  <= 0;
                    end else begin
                        step <= step + 1;
                    end
                end
                default: phase <= PH_HALT;
            endcase
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, the DUT never settled in halt", cycles);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // ======================================================================
    // Stimulus
    // ======================================================================
    task automatic apply_reset();
        @(negedge clk);
        reset = 1'b1;
        repeat (5) @(negedge clk);
        reset = 1'b0;
    endtask

    // Runs the queued program from reset until it halts
    task automatic run_program(input string name);
        int errs_before;
        errs_before = err_count;
        apply_reset();
        while (phase != PH_HALT) @(negedge clk);
        repeat (20) @(negedge clk);             // Word must stay zero
        prog_empty: assert (prog.size() == 0) else begin
            $display("%s stopped with %0d opcodes never fetched", name, prog.size());
            err_count++;
        end
        tests_run++;
        if (err_count == errs_before) begin
            $display("Test %s: ok", name);
        end else begin
            tests_failed++;
            $display("Test %s: %0d errors", name, err_count - errs_before);
        end
    endtask

    initial begin
        int k;
        reset  = 1'b1;
        opcode = NOP;
        flags  = '0;
        void'($urandom(32'hbca8_2ffa));

        prog.push_back(NOP);
        prog.push_back(HLT);
        run_program("reset_init");

        // All 18 opcodes with the halt last
        foreach (plain_ops[i]) prog.push_back(plain_ops[i]);
        foreach (jump_ops[i]) prog.push_back(jump_ops[i]);
        prog.push_back(HLT);
        run_program("fetch_length");

        for (k = 0; k < N_RANDOM; k++) begin
            prog.push_back(plain_ops[$urandom % 13]);
        end
        prog.push_back(HLT);
        run_program("execute_words");

        for (k = 0; k < N_JUMPS; k++) begin
            prog.push_back(jump_ops[$urandom % 4]);
        end
        prog.push_back(HLT);
        run_program("cond_jumps");

        prog.push_back(HLT);
        run_program("halt_hlt");
        prog.push_back(8'ha5);
        run_program("halt_unknown");

        $display("Tests %0d, failed %0d, check errors %0d", tests_run, tests_failed,
                 err_count);
        if (err_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* sim.f */
+incdir+sim
verilog/cpu_ctrl_pkg.sv
verilog/microcode_store.sv
verilog/fetch_sequencer.sv
verilog/step_resolver.sv
verilog/cpu_control.sv
sim/tb_cpu_control.sv

/* Makefile */
obj_dir/Vtb_cpu_control: sim.f verilog/*.sv sim/*.sv sim/*.svh
	verilator --binary --assert -Wno-fatal -f sim.f --top-module tb_cpu_control -j 0

run: obj_dir/Vtb_cpu_control
	@out="$$(./obj_dir/Vtb_cpu_control)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "SIMULATION PASSED"

clean:
	rm -rf obj_dir

.PHONY: run clean
